// File: bench/clock_gen.sv
`timescale 1ns/1ps

module clock_gen #(
  parameter int PERIOD_NS = 40
) (
  output logic o_clk
);

  initial o_clk = 1'b0;

  always #(PERIOD_NS / 2) o_clk = ~o_clk; // half period per phase

endmodule

// File: bench/hart_props.sv
`timescale 1ns/1ps
`include "hart_macros.svh"

module hart_props (
  input logic             i_clk,
  input logic             i_rst,
  input logic             i_ren,
  input logic             i_wen,
  input logic             i_retire_valid,
  input logic             i_retire_halt,
  input logic [`XLEN-1:0] i_retire_inst,
  input logic [`XLEN-1:0] i_retire_pc,
  input logic [`XLEN-1:0] i_retire_next_pc
);

  logic             seen_retire;  // something retired since reset
  logic [`XLEN-1:0] last_next_pc; // next pc of the previous retire

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      seen_retire <= 1'b0;
    end else if (i_retire_valid) begin
      seen_retire  <= 1'b1;
      last_next_pc <= i_retire_next_pc;
    end
  end

  // no memory slot is both a load and a store
  ren_wen_exclusive: assert property (@(posedge i_clk) disable iff (i_rst)
    !(i_ren && i_wen)) else $error("read and write enable high together");

  // pipeline is empty right after a reset cycle
  no_retire_in_reset: assert property (@(posedge i_clk)
    i_rst |=> !i_retire_valid) else $error("retire during reset");

  // ebreak halts in place and never redirects the pc
  halt_is_ebreak: assert property (@(posedge i_clk) disable iff (i_rst)
    i_retire_halt |-> i_retire_inst == `EBREAK_WORD &&
                      i_retire_next_pc == i_retire_pc + `XLEN'(4))
    else $error("halt on a non-ebreak word or with a redirected next pc");

  // each retired pc is the next_pc of the instruction before it
  next_pc_chain: assert property (@(posedge i_clk) disable iff (i_rst)
    (i_retire_valid && seen_retire) |-> i_retire_pc == last_next_pc)
    else $error("retired pc breaks the next_pc chain");

endmodule

bind mem_wb_stage hart_props u_props (
  .i_clk(i_clk), .i_rst(i_rst), .i_ren(o_dmem_ren), .i_wen(o_dmem_wen),
  .i_retire_valid(o_retire_valid), .i_retire_halt(o_retire_halt),
  .i_retire_inst(o_retire_inst), .i_retire_pc(o_retire_pc),
  .i_retire_next_pc(o_retire_next_pc)
);

// the EX/MEM register carries the same stream one cycle early
bind execute_stage hart_props u_props (
  .i_clk(i_clk), .i_rst(i_rst), .i_ren(o_mem_read), .i_wen(o_mem_write),
  .i_retire_valid(o_mem_valid),
  .i_retire_halt(o_mem_valid && o_mem_inst == `EBREAK_WORD),
  .i_retire_inst(o_mem_inst), .i_retire_pc(o_mem_pc),
  .i_retire_next_pc(o_mem_next_pc)
);

// File: bench/hart_tb.sv
`timescale 1ns/1ps
`include "hart_macros.svh"

module hart_tb;

  localparam int REC_BASE   = 256; // word offset of the retire records in the trace
  localparam int REC_WORDS  = 8;   // test pc next_pc inst rd wdata dmem_addr dmem_data
  localparam int MAX_RECS   = 64;
  localparam int WAIT_LIMIT = 20;  // cycles allowed between two retires

  logic                   clk, rst;
  logic [`XLEN-1:0]       imem_raddr, imem_rdata;
  logic [`XLEN-1:0]       dmem_addr, dmem_wdata, dmem_rdata;
  logic                   dmem_ren, dmem_wen;
  logic                   retire_valid, retire_halt, retire_dmem_ren, retire_dmem_wen;
  logic [`XLEN-1:0]       retire_inst, retire_pc, retire_next_pc, retire_rd_wdata;
  logic [`XLEN-1:0]       retire_dmem_addr, retire_dmem_rdata, retire_dmem_wdata;
  logic [`REG_ADDR_W-1:0] retire_rd_waddr;

  logic [`XLEN-1:0] trace_words [0:REC_BASE + REC_WORDS * (MAX_RECS + 1) - 1];
  logic [`XLEN-1:0] imem [0:63];
  logic [`XLEN-1:0] dmem [0:63];
  string            test_names [0:7];
  int               errors, checks, tests_done;

  clock_gen #(.PERIOD_NS(40)) u_clock_gen (.o_clk(clk));

  hart u_hart (
    .i_clk(clk), .i_rst(rst),
    .o_imem_raddr(imem_raddr), .i_imem_rdata(imem_rdata),
    .o_dmem_addr(dmem_addr), .o_dmem_ren(dmem_ren), .o_dmem_wen(dmem_wen),
    .o_dmem_wdata(dmem_wdata), .i_dmem_rdata(dmem_rdata),
    .o_retire_valid(retire_valid), .o_retire_inst(retire_inst),
    .o_retire_halt(retire_halt), .o_retire_pc(retire_pc),
    .o_retire_next_pc(retire_next_pc), .o_retire_rd_waddr(retire_rd_waddr),
    .o_retire_rd_wdata(retire_rd_wdata), .o_retire_dmem_addr(retire_dmem_addr),
    .o_retire_dmem_ren(retire_dmem_ren), .o_retire_dmem_wen(retire_dmem_wen),
    .o_retire_dmem_rdata(retire_dmem_rdata), .o_retire_dmem_wdata(retire_dmem_wdata)
  );

  // word-addressed memories with combinational reads
  assign imem_rdata = imem[imem_raddr[7:2]];
  assign dmem_rdata = dmem_ren ? dmem[dmem_addr[7:2]] : '0; // data only on a read

  always @(posedge clk) begin
    if (dmem_wen) dmem[dmem_addr[7:2]] <= dmem_wdata; // sw lands at the next edge
  end

  task automatic check_value(input logic [`XLEN-1:0] pc, input string what,
                             input logic [`XLEN-1:0] got, input logic [`XLEN-1:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("ERROR at %0t: pc %h %s is %h, expected %h", $time, pc, what, got, exp);
    end
  endtask

  // one negedge per try so that back-to-back retires are each seen once
  task automatic wait_retire(output bit seen);
    int n;
    n = 0;
    seen = 1'b0;
    while (!seen && n < WAIT_LIMIT) begin
      @(negedge clk);
      seen = retire_valid;
      n++;
    end
  endtask

  task automatic compare_record(input int base);
    logic [`XLEN-1:0] pc, inst, rd;
    bit               is_load, is_store;
    pc       = trace_words[base + 1];
    inst     = trace_words[base + 3];
    rd       = trace_words[base + 4];
    is_load  = inst[6:0] == `OPC_LOAD;
    is_store = inst[6:0] == `OPC_STORE;
    check_value(pc, "pc", retire_pc, pc);
    check_value(pc, "next pc", retire_next_pc, trace_words[base + 2]);
    check_value(pc, "instruction", retire_inst, inst);
    check_value(pc, "rd", `XLEN'(retire_rd_waddr), rd);
    if (rd != '0) check_value(pc, "rd data", retire_rd_wdata, trace_words[base + 5]);
    // halt only on the ebreak record
    check_value(pc, "halt", `XLEN'(retire_halt), `XLEN'(inst == `EBREAK_WORD));
    check_value(pc, "dmem ren", `XLEN'(retire_dmem_ren), `XLEN'(is_load));
    check_value(pc, "dmem wen", `XLEN'(retire_dmem_wen), `XLEN'(is_store));
    if (is_load || is_store) begin
      check_value(pc, "dmem addr", retire_dmem_addr, trace_words[base + 6]);
    end
    if (is_load) check_value(pc, "dmem read data", retire_dmem_rdata, trace_words[base + 7]);
    if (is_store) check_value(pc, "dmem write data", retire_dmem_wdata, trace_words[base + 7]);
  endtask

  task automatic report_test(input logic [`XLEN-1:0] num, input int recs, input int errs);
    tests_done++;
    $display("test %0d %s: %0d records, %0d errors", num, test_names[num[2:0]], recs, errs);
  endtask

  initial begin
    int k, rec, base, test_recs, test_errs_base;
    bit seen, done, timed_out;
    rst = 1'b1;
    errors = 0;
    checks = 0;
    tests_done = 0;
    test_names[1] = "alu program";
    test_names[2] = "back-to-back dependences";
    test_names[3] = "store then load";
    test_names[4] = "load-use stall";
    test_names[5] = "branches and jal";
    test_names[6] = "ebreak halt";
    for (k = 0; k < $size(trace_words); k++) begin
      trace_words[k] = 32'h13 | (k << 20); // addi x0, x0, k where nothing is loaded
    end
    $readmemh("bench/hart_trace.txt", trace_words);
    for (k = 0; k < 64; k++) begin
      imem[k] = trace_words[k];
      dmem[k] = 32'hd00d_0000 | k;
    end
    repeat (8) @(posedge clk);
    rst <= 1'b0;

    rec = 0;
    done = 1'b0;
    timed_out = 1'b0;
    test_recs = 0;
    test_errs_base = 0;
    while (!done && !timed_out && rec < MAX_RECS) begin
      base = REC_BASE + rec * REC_WORDS;
      wait_retire(seen);
      if (!seen) begin
        $display("timeout: nothing retired within %0d cycles, waiting for pc %h",
                 WAIT_LIMIT, trace_words[base + 1]);
        timed_out = 1'b1;
      end else begin
        compare_record(base);
        test_recs++;
        done = trace_words[base + 3] == `EBREAK_WORD; // ebreak closes the stream
        if (done || trace_words[base + REC_WORDS] != trace_words[base]) begin
          report_test(trace_words[base], test_recs, errors - test_errs_base);
          test_recs = 0;
          test_errs_base = errors;
        end
        rec++;
      end
    end

    if (!done && !timed_out) begin
      $display("retire stream ran %0d records without reaching ebreak", rec);
    end
    $display("%0d tests, %0d records, %0d checks, %0d errors", tests_done, rec, checks, errors);
    if (errors == 0 && done) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

// File: bench/hart_trace.txt
// program words from address 0, four words per line
@000
00500093 ffd00113 002081b3 40208233
001122b3 00113333 00f14393 40115413
01c15493 00409513 123455b7 00001617
0040e6b3 00a17733 00100793 00f787b3
00f787b3 00f78833 40f808b3 04000913
01092223 00492983 00492a03 001a0ab3
00108663 00100b13 00200b13 00109463
00114663 00100b13 00200b13 00115463
0020e663 00100b13 00200b13 0020f463
00c00bef 00100b13 00200b13 00100073
// retire records from word 0x100, in retire order
// test pc next_pc inst rd rd_wdata dmem_addr dmem_data
@100
1 00 04 00500093 01 00000005 00 0
1 04 08 ffd00113 02 fffffffd 00 0
1 08 0c 002081b3 03 00000002 00 0
1 0c 10 40208233 04 00000008 00 0
1 10 14 001122b3 05 00000001 00 0
1 14 18 00113333 06 00000000 00 0
1 18 1c 00f14393 07 fffffff2 00 0
1 1c 20 40115413 08 fffffffe 00 0
1 20 24 01c15493 09 0000000f 00 0
1 24 28 00409513 0a 00000050 00 0
1 28 2c 123455b7 0b 12345000 00 0
1 2c 30 00001617 0c 0000102c 00 0
1 30 34 0040e6b3 0d 0000000d 00 0
1 34 38 00a17733 0e 00000050 00 0
2 38 3c 00100793 0f 00000001 00 0
2 3c 40 00f787b3 0f 00000002 00 0
2 40 44 00f787b3 0f 00000004 00 0
2 44 48 00f78833 10 00000008 00 0
2 48 4c 40f808b3 11 00000004 00 0
3 4c 50 04000913 12 00000040 00 0
3 50 54 01092223 00 00000000 44 8
3 54 58 00492983 13 00000008 44 8
4 58 5c 00492a03 14 00000008 44 8
4 5c 60 001a0ab3 15 0000000d 00 0
5 60 6c 00108663 00 00000000 00 0
5 6c 70 00109463 00 00000000 00 0
5 70 7c 00114663 00 00000000 00 0
5 7c 80 00115463 00 00000000 00 0
5 80 8c 0020e663 00 00000000 00 0
5 8c 90 0020f463 00 00000000 00 0
5 90 9c 00c00bef 17 00000094 00 0
6 9c a0 00100073 00 00000000 00 0

// File: design/decode_stage.sv
`timescale 1ns/1ps
`include "hart_macros.svh"

module decode_stage import hart_pkg::*; (
  input  logic                   i_clk,
  input  logic                   i_rst,
  input  logic [`XLEN-1:0]       i_id_pc,
  input  logic [`XLEN-1:0]       i_id_inst,
  input  logic                   i_id_valid,
  input  logic                   i_redirect,
  input  logic                   i_wb_we,
  input  logic [`REG_ADDR_W-1:0] i_wb_rd,
  input  logic [`XLEN-1:0]       i_wb_data,
  output logic                   o_stall,
  output logic [`XLEN-1:0]       o_ex_pc,
  output inst_u                  o_ex_inst,
  output logic                   o_ex_valid,
  output logic [`XLEN-1:0]       o_ex_rs1_data,
  output logic [`XLEN-1:0]       o_ex_rs2_data,
  output logic [`XLEN-1:0]       o_ex_imm,
  output alu_op_e                o_ex_alu_op,
  output logic                   o_ex_use_imm,
  output logic                   o_ex_use_pc,
  output logic                   o_ex_branch,
  output logic                   o_ex_jal,
  output logic                   o_ex_mem_read,
  output logic                   o_ex_mem_write,
  output logic                   o_ex_reg_write,
  output wb_sel_e                o_ex_wb_sel
);

  inst_u                  inst;
  logic [`REG_ADDR_W-1:0] rs1, rs2;
  logic                   use_rs1, use_rs2;
  logic [`XLEN-1:0]       imm, rs1_val, rs2_val;
  alu_op_e                alu_op;
  logic                   use_imm, use_pc, is_branch, is_jal, is_load, is_store, reg_write;
  wb_sel_e                wb_sel;
  logic [`XLEN-1:0]       rf [1:(1 << `REG_ADDR_W) - 1]; // x0 has no storage

  assign inst = i_id_inst;
  assign rs1  = inst.r.rs1;
  assign rs2  = inst.r.rs2;

  // alt picks sub for op and sra for the shift-right encodings
  function automatic alu_op_e alu_decode(input logic [2:0] funct3, input logic alt);
    case (funct3)
      3'b000:  alu_decode = alt ? ALU_SUB : ALU_ADD;
      3'b001:  alu_decode = ALU_SLL;
      3'b010:  alu_decode = ALU_SLT;
      3'b011:  alu_decode = ALU_SLTU;
      3'b100:  alu_decode = ALU_XOR;
      3'b101:  alu_decode = alt ? ALU_SRA : ALU_SRL;
      3'b110:  alu_decode = ALU_OR;
      default: alu_decode = ALU_AND;
    endcase
  endfunction

  always_comb begin
    alu_op    = ALU_ADD; // address and auipc sums by default
    use_imm   = 1'b1;
    use_pc    = 1'b0;
    use_rs1   = 1'b1;
    use_rs2   = 1'b0;
    is_branch = 1'b0;
    is_jal    = 1'b0;
    is_load   = 1'b0;
    is_store  = 1'b0;
    reg_write = 1'b0;
    wb_sel    = WB_ALU;
    imm       = {{20{inst.i.imm[11]}}, inst.i.imm}; // i-type
    case (inst.r.opcode)
      `OPC_OP: begin
        alu_op    = alu_decode(inst.r.funct3, inst.r.funct7[5]);
        use_imm   = 1'b0;
        use_rs2   = 1'b1;
        reg_write = 1'b1;
      end
      `OPC_OP_IMM: begin
        // bit 30 only means sra for shifts, addi has no sub form
        alu_op    = alu_decode(inst.i.funct3, inst.i.funct3 == 3'b101 && inst.r.funct7[5]);
        reg_write = 1'b1;
      end
      `OPC_LUI: begin
        alu_op    = ALU_PASS_B;
        imm       = {inst.u.imm, 12'b0};
        use_rs1   = 1'b0;
        reg_write = 1'b1;
      end
      `OPC_AUIPC: begin
        use_pc    = 1'b1;
        imm       = {inst.u.imm, 12'b0};
        use_rs1   = 1'b0;
        reg_write = 1'b1;
      end
      `OPC_LOAD: begin
        is_load   = 1'b1;
        reg_write = 1'b1;
        wb_sel    = WB_MEM;
      end
      `OPC_STORE: begin
        is_store = 1'b1;
        use_rs2  = 1'b1;
        imm      = {{20{inst.s.imm_hi[6]}}, inst.s.imm_hi, inst.s.imm_lo};
      end
      `OPC_BRANCH: begin
        is_branch = 1'b1;
        use_rs2   = 1'b1;
        imm = {{19{inst.b.imm12}}, inst.b.imm12, inst.b.imm11, inst.b.imm10_5,
               inst.b.imm4_1, 1'b0};
      end
      `OPC_JAL: begin
        is_jal    = 1'b1;
        use_rs1   = 1'b0;
        reg_write = 1'b1; // link register gets pc+4
        wb_sel    = WB_PC4;
        imm = {{11{inst.j.imm20}}, inst.j.imm20, inst.j.imm19_12, inst.j.imm11,
               inst.j.imm10_1, 1'b0};
      end
      default: use_rs1 = 1'b0; // ebreak and unknown words do nothing
    endcase
  end

  // register file, a write in this cycle is seen by the read
  always_ff @(posedge i_clk) begin
    if (i_wb_we && i_wb_rd != '0) rf[i_wb_rd] <= i_wb_data;
  end

  assign rs1_val = (rs1 == '0) ? '0 : (i_wb_we && i_wb_rd == rs1) ? i_wb_data : rf[rs1];
  assign rs2_val = (rs2 == '0) ? '0 : (i_wb_we && i_wb_rd == rs2) ? i_wb_data : rf[rs2];

  // load in execute feeding this instruction, mem_read is already 0 for bubbles
  assign o_stall = i_id_valid && o_ex_mem_read && o_ex_inst.r.rd != '0 &&
                   ((use_rs1 && o_ex_inst.r.rd == rs1) || (use_rs2 && o_ex_inst.r.rd == rs2));

  // ID/EX control, bubble on stall, redirect or empty slot
  always_ff @(posedge i_clk) begin
    if (i_rst || i_redirect || o_stall || !i_id_valid) begin
      o_ex_valid     <= 1'b0;
      o_ex_branch    <= 1'b0;
      o_ex_jal       <= 1'b0;
      o_ex_mem_read  <= 1'b0;
      o_ex_mem_write <= 1'b0;
      o_ex_reg_write <= 1'b0;
    end else begin
      o_ex_valid     <= 1'b1;
      o_ex_branch    <= is_branch;
      o_ex_jal       <= is_jal;
      o_ex_mem_read  <= is_load;
      o_ex_mem_write <= is_store;
      o_ex_reg_write <= reg_write;
    end
  end

  always_ff @(posedge i_clk) begin
    o_ex_pc       <= i_id_pc;
    o_ex_inst     <= inst;
    o_ex_rs1_data <= rs1_val;
    o_ex_rs2_data <= rs2_val;
    o_ex_imm      <= imm;
    o_ex_alu_op   <= alu_op;
    o_ex_use_imm  <= use_imm;
    o_ex_use_pc   <= use_pc;
    o_ex_wb_sel   <= wb_sel;
  end

endmodule

// File: design/execute_stage.sv
`timescale 1ns/1ps
`include "hart_macros.svh"

module execute_stage import hart_pkg::*; (
  input  logic                   i_clk,
  input  logic                   i_rst,
  input  logic [`XLEN-1:0]       i_ex_pc,
  input  inst_u                  i_ex_inst,
  input  logic                   i_ex_valid,
  input  logic [`XLEN-1:0]       i_ex_rs1_data,
  input  logic [`XLEN-1:0]       i_ex_rs2_data,
  input  logic [`XLEN-1:0]       i_ex_imm,
  input  alu_op_e                i_ex_alu_op,
  input  logic                   i_ex_use_imm,
  input  logic                   i_ex_use_pc,
  input  logic                   i_ex_branch,
  input  logic                   i_ex_jal,
  input  logic                   i_ex_mem_read,
  input  logic                   i_ex_mem_write,
  input  logic                   i_ex_reg_write,
  input  wb_sel_e                i_ex_wb_sel,
  input  logic                   i_wb_we,
  input  logic [`REG_ADDR_W-1:0] i_wb_rd,
  input  logic [`XLEN-1:0]       i_wb_data,
  output logic                   o_redirect,
  output logic [`XLEN-1:0]       o_target,
  output logic [`XLEN-1:0]       o_mem_pc,
  output inst_u                  o_mem_inst,
  output logic                   o_mem_valid,
  output logic [`XLEN-1:0]       o_mem_alu,
  output logic [`XLEN-1:0]       o_mem_store_data,
  output logic                   o_mem_read,
  output logic                   o_mem_write,
  output logic                   o_mem_reg_write,
  output wb_sel_e                o_mem_wb_sel,
  output logic [`XLEN-1:0]       o_mem_next_pc
);

  logic [`XLEN-1:0] mem_result, rs1_val, rs2_val, op_a, op_b, alu, pc_plus4, next_pc;
  logic             cond, take;

  // value the memory-stage instruction will write, jal links pc+4
  assign mem_result = (o_mem_wb_sel == WB_PC4) ? o_mem_pc + `XLEN'(4) : o_mem_alu;

  // youngest producer wins: memory stage, then writeback, then register file
  function automatic logic [`XLEN-1:0] fwd(input logic [`REG_ADDR_W-1:0] rs,
                                           input logic [`XLEN-1:0]       rf_val);
    if (rs != '0 && o_mem_reg_write && o_mem_inst.r.rd == rs) fwd = mem_result;
    else if (rs != '0 && i_wb_we && i_wb_rd == rs) fwd = i_wb_data;
    else fwd = rf_val;
  endfunction

  always_comb begin
    rs1_val = fwd(i_ex_inst.r.rs1, i_ex_rs1_data);
    rs2_val = fwd(i_ex_inst.r.rs2, i_ex_rs2_data);
  end

  assign op_a = i_ex_use_pc  ? i_ex_pc  : rs1_val; // auipc
  assign op_b = i_ex_use_imm ? i_ex_imm : rs2_val;

  always_comb begin
    case (i_ex_alu_op)
      ALU_ADD:  alu = op_a + op_b;
      ALU_SUB:  alu = op_a - op_b;
      ALU_SLL:  alu = op_a << op_b[4:0];
      ALU_SLT:  alu = `XLEN'($signed(op_a) < $signed(op_b));
      ALU_SLTU: alu = `XLEN'(op_a < op_b);
      ALU_XOR:  alu = op_a ^ op_b;
      ALU_SRL:  alu = op_a >> op_b[4:0];
      ALU_SRA:  alu = $unsigned($signed(op_a) >>> op_b[4:0]);
      ALU_OR:   alu = op_a | op_b;
      ALU_AND:  alu = op_a & op_b;
      default:  alu = op_b; // pass-b for lui
    endcase
  end

  // branch compare on forwarded operands
  always_comb begin
    case (i_ex_inst.b.funct3)
      3'b000:  cond = rs1_val == rs2_val;                   // beq
      3'b001:  cond = rs1_val != rs2_val;                   // bne
      3'b100:  cond = $signed(rs1_val) <  $signed(rs2_val); // blt
      3'b101:  cond = $signed(rs1_val) >= $signed(rs2_val); // bge
      3'b110:  cond = rs1_val <  rs2_val;                   // bltu
      3'b111:  cond = rs1_val >= rs2_val;                   // bgeu
      default: cond = 1'b0;
    endcase
  end

  assign take       = i_ex_valid && (i_ex_jal || (i_ex_branch && cond));
  assign o_target   = i_ex_pc + i_ex_imm; // shared by branches and jal
  assign o_redirect = take;               // same-cycle pulse into fetch and decode
  assign pc_plus4   = i_ex_pc + `XLEN'(4);
  assign next_pc    = take ? o_target : pc_plus4;

  // EX/MEM control
  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      o_mem_valid     <= 1'b0;
      o_mem_read      <= 1'b0;
      o_mem_write     <= 1'b0;
      o_mem_reg_write <= 1'b0;
    end else begin
      o_mem_valid     <= i_ex_valid;
      o_mem_read      <= i_ex_mem_read;
      o_mem_write     <= i_ex_mem_write;
      o_mem_reg_write <= i_ex_reg_write;
    end
  end

  always_ff @(posedge i_clk) begin
    o_mem_pc         <= i_ex_pc;
    o_mem_inst       <= i_ex_inst;
    o_mem_alu        <= alu;
    o_mem_store_data <= rs2_val; // forwarded sw data
    o_mem_wb_sel     <= i_ex_wb_sel;
    o_mem_next_pc    <= next_pc;
  end

endmodule

// File: design/fetch_stage.sv
`timescale 1ns/1ps
`include "hart_macros.svh"

module fetch_stage (
  input  logic             i_clk,
  input  logic             i_rst,
  input  logic             i_stall,    // load-use hold from decode
  input  logic             i_redirect, // taken branch or jal in execute
  input  logic [`XLEN-1:0] i_target,
  input  logic [`XLEN-1:0] i_imem_rdata,
  output logic [`XLEN-1:0] o_imem_raddr,
  output logic [`XLEN-1:0] o_id_pc,
  output logic [`XLEN-1:0] o_id_inst,
  output logic             o_id_valid
);

  logic [`XLEN-1:0] pc;

  assign o_imem_raddr = pc; // imem answers in the same cycle

  // redirect beats stall, the stalled instruction is squashed anyway
  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      pc <= `RESET_PC;
    end else if (i_redirect) begin
      pc <= i_target;
    end else if (!i_stall) begin
      pc <= pc + `XLEN'(4);
    end
  end

  // IF/ID valid, a redirect turns the fetched word into a bubble
  always_ff @(posedge i_clk) begin
    if (i_rst || i_redirect) begin
      o_id_valid <= 1'b0;
    end else if (!i_stall) begin
      o_id_valid <= 1'b1;
    end
  end

  always_ff @(posedge i_clk) begin
    if (!i_stall) begin
      o_id_pc   <= pc;
      o_id_inst <= i_imem_rdata;
    end
  end

endmodule

// File: design/hart.sv
`timescale 1ns/1ps
`include "hart_macros.svh"

module hart import hart_pkg::*; (
  input  logic                   i_clk,
  input  logic                   i_rst,
  output logic [`XLEN-1:0]       o_imem_raddr,
  input  logic [`XLEN-1:0]       i_imem_rdata,
  output logic [`XLEN-1:0]       o_dmem_addr,
  output logic                   o_dmem_ren,
  output logic                   o_dmem_wen,
  output logic [`XLEN-1:0]       o_dmem_wdata,
  input  logic [`XLEN-1:0]       i_dmem_rdata,
  output logic                   o_retire_valid,
  output logic [`XLEN-1:0]       o_retire_inst,
  output logic                   o_retire_halt,
  output logic [`XLEN-1:0]       o_retire_pc,
  output logic [`XLEN-1:0]       o_retire_next_pc,
  output logic [`REG_ADDR_W-1:0] o_retire_rd_waddr,
  output logic [`XLEN-1:0]       o_retire_rd_wdata,
  output logic [`XLEN-1:0]       o_retire_dmem_addr,
  output logic                   o_retire_dmem_ren,
  output logic                   o_retire_dmem_wen,
  output logic [`XLEN-1:0]       o_retire_dmem_rdata,
  output logic [`XLEN-1:0]       o_retire_dmem_wdata
);

  // hazard and redirect
  logic                   stall, redirect;
  logic [`XLEN-1:0]       target;
  // IF/ID
  logic [`XLEN-1:0]       id_pc, id_inst;
  logic                   id_valid;
  // ID/EX
  logic [`XLEN-1:0]       ex_pc, ex_rs1_data, ex_rs2_data, ex_imm;
  inst_u                  ex_inst;
  alu_op_e                ex_alu_op;
  wb_sel_e                ex_wb_sel;
  logic                   ex_valid, ex_use_imm, ex_use_pc, ex_branch, ex_jal;
  logic                   ex_mem_read, ex_mem_write, ex_reg_write;
  // EX/MEM
  logic [`XLEN-1:0]       mem_pc, mem_alu, mem_store_data, mem_next_pc;
  inst_u                  mem_inst;
  wb_sel_e                mem_wb_sel;
  logic                   mem_valid, mem_read, mem_write, mem_reg_write;
  // writeback into the register file and the forwarding path
  logic                   wb_we;
  logic [`REG_ADDR_W-1:0] wb_rd;
  logic [`XLEN-1:0]       wb_data;

  fetch_stage u_fetch (
    .i_clk, .i_rst, .i_stall(stall), .i_redirect(redirect), .i_target(target),
    .i_imem_rdata, .o_imem_raddr,
    .o_id_pc(id_pc), .o_id_inst(id_inst), .o_id_valid(id_valid)
  );

  decode_stage u_decode (
    .i_clk, .i_rst, .i_id_pc(id_pc), .i_id_inst(id_inst), .i_id_valid(id_valid),
    .i_redirect(redirect), .i_wb_we(wb_we), .i_wb_rd(wb_rd), .i_wb_data(wb_data),
    .o_stall(stall), .o_ex_pc(ex_pc), .o_ex_inst(ex_inst), .o_ex_valid(ex_valid),
    .o_ex_rs1_data(ex_rs1_data), .o_ex_rs2_data(ex_rs2_data), .o_ex_imm(ex_imm),
    .o_ex_alu_op(ex_alu_op), .o_ex_use_imm(ex_use_imm), .o_ex_use_pc(ex_use_pc),
    .o_ex_branch(ex_branch), .o_ex_jal(ex_jal), .o_ex_mem_read(ex_mem_read),
    .o_ex_mem_write(ex_mem_write), .o_ex_reg_write(ex_reg_write), .o_ex_wb_sel(ex_wb_sel)
  );

  execute_stage u_execute (
    .i_clk, .i_rst, .i_ex_pc(ex_pc), .i_ex_inst(ex_inst), .i_ex_valid(ex_valid),
    .i_ex_rs1_data(ex_rs1_data), .i_ex_rs2_data(ex_rs2_data), .i_ex_imm(ex_imm),
    .i_ex_alu_op(ex_alu_op), .i_ex_use_imm(ex_use_imm), .i_ex_use_pc(ex_use_pc),
    .i_ex_branch(ex_branch), .i_ex_jal(ex_jal), .i_ex_mem_read(ex_mem_read),
    .i_ex_mem_write(ex_mem_write), .i_ex_reg_write(ex_reg_write), .i_ex_wb_sel(ex_wb_sel),
    .i_wb_we(wb_we), .i_wb_rd(wb_rd), .i_wb_data(wb_data),
    .o_redirect(redirect), .o_target(target), .o_mem_pc(mem_pc), .o_mem_inst(mem_inst),
    .o_mem_valid(mem_valid), .o_mem_alu(mem_alu), .o_mem_store_data(mem_store_data),
    .o_mem_read(mem_read), .o_mem_write(mem_write), .o_mem_reg_write(mem_reg_write),
    .o_mem_wb_sel(mem_wb_sel), .o_mem_next_pc(mem_next_pc)
  );

  mem_wb_stage u_mem_wb (
    .i_clk, .i_rst, .i_mem_pc(mem_pc), .i_mem_inst(mem_inst), .i_mem_valid(mem_valid),
    .i_mem_alu(mem_alu), .i_mem_store_data(mem_store_data), .i_mem_read(mem_read),
    .i_mem_write(mem_write), .i_mem_reg_write(mem_reg_write), .i_mem_wb_sel(mem_wb_sel),
    .i_mem_next_pc(mem_next_pc), .i_dmem_rdata,
    .o_dmem_addr, .o_dmem_ren, .o_dmem_wen, .o_dmem_wdata,
    .o_wb_we(wb_we), .o_wb_rd(wb_rd), .o_wb_data(wb_data),
    .o_retire_valid, .o_retire_inst, .o_retire_halt, .o_retire_pc, .o_retire_next_pc,
    .o_retire_rd_waddr, .o_retire_rd_wdata, .o_retire_dmem_addr, .o_retire_dmem_ren,
    .o_retire_dmem_wen, .o_retire_dmem_rdata, .o_retire_dmem_wdata
  );

endmodule

// File: design/hart_macros.svh
`ifndef HART_MACROS_SVH
`define HART_MACROS_SVH

// datapath and address width
`define XLEN       32
`define REG_ADDR_W 5

// first fetch address out of reset
`define RESET_PC   32'h0000_0000

// major opcodes of the supported rv32i subset
`define OPC_OP     7'b0110011 // reg-reg alu
`define OPC_OP_IMM 7'b0010011 // reg-imm alu
`define OPC_LUI    7'b0110111
`define OPC_AUIPC  7'b0010111
`define OPC_LOAD   7'b0000011 // lw only
`define OPC_STORE  7'b0100011 // sw only
`define OPC_BRANCH 7'b1100011
`define OPC_JAL    7'b1101111
`define OPC_SYSTEM 7'b1110011 // ebreak lives here

// ebreak is the one system word the hart recognises, used as halt
`define EBREAK_WORD 32'h0010_0073

`endif

// File: design/hart_pkg.sv
package hart_pkg;

  // one instruction word, decoded in six formats
  typedef union packed {
    struct packed {
      logic [6:0] funct7;
      logic [4:0] rs2;
      logic [4:0] rs1;
      logic [2:0] funct3;
      logic [4:0] rd;
      logic [6:0] opcode;
    } r;
    struct packed {
      logic [11:0] imm;
      logic [4:0]  rs1;
      logic [2:0]  funct3;
      logic [4:0]  rd;
      logic [6:0]  opcode;
    } i;
    struct packed {
      logic [6:0] imm_hi; // imm[11:5]
      logic [4:0] rs2;
      logic [4:0] rs1;
      logic [2:0] funct3;
      logic [4:0] imm_lo; // imm[4:0]
      logic [6:0] opcode;
    } s;
    struct packed {
      logic       imm12;
      logic [5:0] imm10_5;
      logic [4:0] rs2;
      logic [4:0] rs1;
      logic [2:0] funct3; // branch condition
      logic [3:0] imm4_1;
      logic       imm11;
      logic [6:0] opcode;
    } b;
    struct packed {
      logic [19:0] imm; // imm[31:12]
      logic [4:0]  rd;
      logic [6:0]  opcode;
    } u;
    struct packed {
      logic       imm20;
      logic [9:0] imm10_1;
      logic       imm11;
      logic [7:0] imm19_12;
      logic [4:0] rd;
      logic [6:0] opcode;
    } j;
  } inst_u;

  typedef enum logic [3:0] {
    ALU_ADD, ALU_SUB, ALU_SLL, ALU_SLT, ALU_SLTU, ALU_XOR,
    ALU_SRL, ALU_SRA, ALU_OR, ALU_AND,
    ALU_PASS_B // lui passes the immediate straight through
  } alu_op_e;

  // writeback source
  typedef enum logic [1:0] {
    WB_ALU,
    WB_MEM,
    WB_PC4 // jal link value
  } wb_sel_e;

endpackage

// File: design/mem_wb_stage.sv
`timescale 1ns/1ps
`include "hart_macros.svh"

module mem_wb_stage import hart_pkg::*; (
  input  logic                   i_clk,
  input  logic                   i_rst,
  input  logic [`XLEN-1:0]       i_mem_pc,
  input  inst_u                  i_mem_inst,
  input  logic                   i_mem_valid,
  input  logic [`XLEN-1:0]       i_mem_alu,
  input  logic [`XLEN-1:0]       i_mem_store_data,
  input  logic                   i_mem_read,
  input  logic                   i_mem_write,
  input  logic                   i_mem_reg_write,
  input  wb_sel_e                i_mem_wb_sel,
  input  logic [`XLEN-1:0]       i_mem_next_pc,
  input  logic [`XLEN-1:0]       i_dmem_rdata,
  output logic [`XLEN-1:0]       o_dmem_addr,
  output logic                   o_dmem_ren,
  output logic                   o_dmem_wen,
  output logic [`XLEN-1:0]       o_dmem_wdata,
  output logic                   o_wb_we,
  output logic [`REG_ADDR_W-1:0] o_wb_rd,
  output logic [`XLEN-1:0]       o_wb_data,
  output logic                   o_retire_valid,
  output logic [`XLEN-1:0]       o_retire_inst,
  output logic                   o_retire_halt,
  output logic [`XLEN-1:0]       o_retire_pc,
  output logic [`XLEN-1:0]       o_retire_next_pc,
  output logic [`REG_ADDR_W-1:0] o_retire_rd_waddr,
  output logic [`XLEN-1:0]       o_retire_rd_wdata,
  output logic [`XLEN-1:0]       o_retire_dmem_addr,
  output logic                   o_retire_dmem_ren,
  output logic                   o_retire_dmem_wen,
  output logic [`XLEN-1:0]       o_retire_dmem_rdata,
  output logic [`XLEN-1:0]       o_retire_dmem_wdata
);

  logic             wb_valid, wb_reg_write, wb_ren, wb_wen;
  inst_u            wb_inst;
  wb_sel_e          wb_sel;
  logic [`XLEN-1:0] wb_pc, wb_next_pc, wb_alu, wb_rdata, wb_wdata;

  // word access only, address comes straight from the alu sum
  assign o_dmem_addr  = i_mem_alu;
  assign o_dmem_ren   = i_mem_valid && i_mem_read;
  assign o_dmem_wen   = i_mem_valid && i_mem_write;
  assign o_dmem_wdata = i_mem_store_data;

  // MEM/WB control
  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      wb_valid     <= 1'b0;
      wb_reg_write <= 1'b0;
      wb_ren       <= 1'b0;
      wb_wen       <= 1'b0;
    end else begin
      wb_valid     <= i_mem_valid;
      wb_reg_write <= i_mem_valid && i_mem_reg_write;
      wb_ren       <= o_dmem_ren;
      wb_wen       <= o_dmem_wen;
    end
  end

  always_ff @(posedge i_clk) begin
    wb_pc      <= i_mem_pc;
    wb_inst    <= i_mem_inst;
    wb_sel     <= i_mem_wb_sel;
    wb_next_pc <= i_mem_next_pc;
    wb_alu     <= i_mem_alu;
    wb_rdata   <= i_dmem_rdata; // load data captured at the end of mem
    wb_wdata   <= i_mem_store_data;
  end

  always_comb begin
    case (wb_sel)
      WB_MEM:  o_wb_data = wb_rdata;
      WB_PC4:  o_wb_data = wb_pc + `XLEN'(4);
      default: o_wb_data = wb_alu;
    endcase
  end

  assign o_wb_we = wb_reg_write;
  assign o_wb_rd = wb_inst.r.rd;

  // retire port mirrors the writeback slot
  assign o_retire_valid      = wb_valid;
  assign o_retire_inst       = wb_inst;
  assign o_retire_halt       = wb_valid && wb_inst == `EBREAK_WORD;
  assign o_retire_pc         = wb_pc;
  assign o_retire_next_pc    = wb_next_pc;
  assign o_retire_rd_waddr   = wb_reg_write ? wb_inst.r.rd : '0; // 0 for sw and branches
  assign o_retire_rd_wdata   = o_wb_data;
  assign o_retire_dmem_addr  = wb_alu;
  assign o_retire_dmem_ren   = wb_ren;
  assign o_retire_dmem_wen   = wb_wen;
  assign o_retire_dmem_rdata = wb_rdata;
  assign o_retire_dmem_wdata = wb_wdata;

endmodule

// File: run_sim.sh
#!/bin/sh
# build the hart testbench with Verilator and run it from the project root
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert \
  --top-module hart_tb \
  -f sources.f \
  -o hart_sim

# a crashed or stopped run keeps its failing status
./obj_dir/hart_sim > sim.log 2>&1 || { cat sim.log; exit 1; }
cat sim.log

if grep -q "Simulation failed" sim.log; then
  echo "run_sim: testbench reported a failure, see sim.log"
  exit 1
fi
echo "run_sim: finished"

// File: sources.f
+incdir+design
design/hart_pkg.sv
design/fetch_stage.sv
design/decode_stage.sv
design/execute_stage.sv
design/mem_wb_stage.sv
design/hart.sv
bench/clock_gen.sv
bench/hart_props.sv
bench/hart_tb.sv
